// File: Bender.yml
package:
  name: bus_fabric

sources:
  - files:
      - rtl/soc_bus_pkg.sv
      - rtl/region_decode.sv
      - rtl/gpio_regs.sv
      - rtl/sample_capture.sv
      - rtl/scratch_ram.sv
      - rtl/bus_response.sv
      - rtl/bus_fabric_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_bus_fabric.sv

// File: rtl/bus_fabric_top.sv
`timescale 1ns/1ps

module bus_fabric_top #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                                clk_rv,
    input  logic                                rst_rv_,
    input  soc_bus_pkg::bus_req_t               req,
    input  logic [soc_bus_pkg::DELAY_SEL_W-1:0] delay_sel_det,
    input  soc_bus_pkg::pin_in_t                pins_in,
    input  logic                                sample_strobe,
    input  soc_bus_pkg::sample_t                channel_a,
    input  soc_bus_pkg::sample_t                channel_b,
    output soc_bus_pkg::bus_rsp_t               rsp,
    output soc_bus_pkg::gpio_pins_t             pins_out,
    output logic [soc_bus_pkg::DELAY_SEL_W-1:0] delay_sel,
    output soc_bus_pkg::stereo_t                codec_out,
    output logic                                bus_error
);
    import soc_bus_pkg::*;

    region_t     region;
    logic        sel;
    logic [31:0] gpio_rdata;
    logic [31:0] ram_rdata;
    stereo_t     sample_pair;
    logic        sample_rdy;
    logic        sample_ovfl;
    logic        sample_clear;

    // --------------------------------------------------------------------------
    // Decode stage
    // --------------------------------------------------------------------------

    region_decode #(
        .RAM_WORDS(RAM_WORDS)
    ) u_region_decode (
        .clk_rv   (clk_rv),
        .rst_rv_  (rst_rv_),
        .req      (req),
        .rsp_ready(rsp.ready),
        .region   (region),
        .sel      (sel),
        .bus_error(bus_error)
    );

    // --------------------------------------------------------------------------
    // Execute stage
    // --------------------------------------------------------------------------

    gpio_regs u_gpio_regs (
        .clk_rv       (clk_rv),
        .rst_rv_      (rst_rv_),
        .sel          (sel),
        .region       (region),
        .req          (req),
        .delay_sel_det(delay_sel_det),
        .pins_in      (pins_in),
        .sample_pair  (sample_pair),
        .sample_rdy   (sample_rdy),
        .sample_ovfl  (sample_ovfl),
        .pins_out     (pins_out),
        .delay_sel    (delay_sel),
        .sample_clear (sample_clear),
        .rdata        (gpio_rdata)
    );

    sample_capture u_sample_capture (
        .clk_rv       (clk_rv),
        .rst_rv_      (rst_rv_),
        .sample_strobe(sample_strobe),
        .channel_a    (channel_a),
        .channel_b    (channel_b),
        .sample_clear (sample_clear),
        .sample_pair  (sample_pair),
        .sample_rdy   (sample_rdy),
        .sample_ovfl  (sample_ovfl),
        .codec_out    (codec_out)
    );

    scratch_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_scratch_ram (
        .clk_rv(clk_rv),
        .sel   (sel),
        .region(region),
        .req   (req),
        .rdata (ram_rdata)
    );

    // Result stage
    bus_response u_bus_response (
        .clk_rv    (clk_rv),
        .rst_rv_   (rst_rv_),
        .sel       (sel),
        .region    (region),
        .gpio_rdata(gpio_rdata),
        .ram_rdata (ram_rdata),
        .rsp       (rsp)
    );

endmodule

// File: rtl/bus_response.sv
`timescale 1ns/1ps

module bus_response (
    input  logic                  clk_rv,
    input  logic                  rst_rv_,
    input  logic                  sel,
    input  soc_bus_pkg::region_t  region,
    input  logic [31:0]           gpio_rdata,
    input  logic [31:0]           ram_rdata,
    output soc_bus_pkg::bus_rsp_t rsp
);
    import soc_bus_pkg::*;

    logic ready_q;

    // --------------------------------------------------------------------------
    // Ready, one cycle after sel for every region
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv_) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= sel;
        end
    end

    // Both sources are registered on the edge that raises ready,
    // and region stays fixed until the next access starts
    always_comb begin
        rsp.ready = ready_q;
        if (region.ram) begin
            rsp.rdata = ram_rdata;
        end else if (region.gpio) begin
            rsp.rdata = gpio_rdata;
        end else begin
            rsp.rdata = BUS_ERROR_DATA;
        end
    end

endmodule

// File: rtl/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs (
    input  logic                                clk_rv,
    input  logic                                rst_rv_,
    input  logic                                sel,
    input  soc_bus_pkg::region_t                region,
    input  soc_bus_pkg::bus_req_t               req,
    input  logic [soc_bus_pkg::DELAY_SEL_W-1:0] delay_sel_det,
    input  soc_bus_pkg::pin_in_t                pins_in,
    input  soc_bus_pkg::stereo_t                sample_pair,
    input  logic                                sample_rdy,
    input  logic                                sample_ovfl,
    output soc_bus_pkg::gpio_pins_t             pins_out,
    output logic [soc_bus_pkg::DELAY_SEL_W-1:0] delay_sel,
    output logic                                sample_clear,
    output logic [31:0]                         rdata
);
    import soc_bus_pkg::*;

    logic       acc;
    logic       wr;
    logic       rd;
    logic [3:0] idx;
    logic       led_red;
    logic       led_green;
    logic       led_blue;
    logic       spi_cs_b;
    logic       spi_sck;
    logic       spi_mosi;
    logic       usb_reset_b;
    logic       codec_scl;
    logic       codec_sda;

    assign acc = sel && region.gpio;
    assign wr  = acc && (req.wstrb != 4'b0000);
    assign rd  = acc && (req.wstrb == 4'b0000);
    assign idx = req.addr[5:2];

    // Reading the sample word consumes it
    assign sample_clear = rd && (idx == REG_SAMPLE);

    // --------------------------------------------------------------------------
    // Register writes
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv_) begin
            delay_sel   <= delay_sel_det;
            led_red     <= 1'b0;
            led_green   <= 1'b0;
            led_blue    <= 1'b0;
            spi_cs_b    <= 1'b1;
            spi_sck     <= 1'b0;
            spi_mosi    <= 1'b0;
            usb_reset_b <= 1'b0;
            codec_scl   <= 1'b1;
            codec_sda   <= 1'b1;
        end else if (wr) begin
            case (idx)
                REG_DELAY_SEL: delay_sel <= req.wdata[DELAY_SEL_W-1:0];
                REG_LEDS: begin
                    led_red   <= req.wdata[2];
                    led_green <= req.wdata[1];
                    led_blue  <= req.wdata[0];
                end
                REG_SPI_CS:    spi_cs_b    <= req.wdata[0];
                REG_SPI_SCK:   spi_sck     <= req.wdata[0];
                REG_SPI_MOSI:  spi_mosi    <= req.wdata[0];
                REG_USB_RST:   usb_reset_b <= req.wdata[0];
                REG_CODEC_SCL: codec_scl   <= req.wdata[0];
                REG_CODEC_SDA: codec_sda   <= req.wdata[0];
                default: ;
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // Zero-extended read data
    // --------------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (rd) begin
            case (idx)
                REG_DELAY_SEL:   rdata <= 32'(delay_sel);
                REG_LEDS:        rdata <= {29'd0, led_red, led_green, led_blue};
                REG_SAMPLE:      rdata <= sample_pair;
                REG_SPI_MISO:    rdata <= {31'd0, pins_in.spi_miso};
                REG_CODEC_SCL:   rdata <= {31'd0, pins_in.codec_scl_in};
                REG_CODEC_SDA:   rdata <= {31'd0, pins_in.codec_sda_in};
                REG_SAMPLE_STAT: rdata <= {30'd0, sample_ovfl, sample_rdy};
                default:         rdata <= '0;
            endcase
        end
    end

    // LEDs are active low on the board
    assign pins_out.led_red_b   = !led_red;
    assign pins_out.led_green_b = !led_green;
    assign pins_out.led_blue_b  = !led_blue;
    assign pins_out.spi_cs_b    = spi_cs_b;
    assign pins_out.spi_sck     = spi_sck;
    assign pins_out.spi_mosi    = spi_mosi;
    assign pins_out.usb_reset_b = usb_reset_b;

    // Open drain where a register value of 1 releases the line
    assign pins_out.codec_scl_drive_low = !codec_scl;
    assign pins_out.codec_sda_drive_low = !codec_sda;

endmodule

// File: rtl/region_decode.sv
`timescale 1ns/1ps

module region_decode #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                  clk_rv,
    input  logic                  rst_rv_,
    input  soc_bus_pkg::bus_req_t req,
    input  logic                  rsp_ready,
    output soc_bus_pkg::region_t  region,
    output logic                  sel,
    output logic                  bus_error
);
    import soc_bus_pkg::*;

    localparam logic [31:0] RAM_SPAN = 32'(4 * RAM_WORDS);

    logic    valid_q;
    logic    start;
    logic    in_gpio;
    logic    in_ram;
    region_t region_next;

    // First cycle of an access, valid was low at the previous edge
    assign start = req.valid && !valid_q;

    assign in_gpio = (req.addr >= GPIO_BASE) && (req.addr < GPIO_BASE + GPIO_SPAN);
    assign in_ram  = (req.addr >= RAM_BASE) && (req.addr < RAM_BASE + RAM_SPAN);

    always_comb begin
        region_next.gpio     = in_gpio;
        region_next.ram      = in_ram;
        region_next.unmapped = !in_gpio && !in_ram;
    end

    // Region is held for the whole access so the result stage can use it
    always_ff @(posedge clk_rv) begin
        if (!rst_rv_) begin
            valid_q <= 1'b0;
            sel     <= 1'b0;
            region  <= '0;
        end else begin
            valid_q <= req.valid;
            sel     <= start;
            if (start) begin
                region <= region_next;
            end
        end
    end

    // Sticky error interrupt, set when an unmapped access completes
    always_ff @(posedge clk_rv) begin
        if (!rst_rv_) begin
            bus_error <= 1'b0;
        end else if (rsp_ready && region.unmapped) begin
            bus_error <= 1'b1;
        end
    end

endmodule

// File: rtl/sample_capture.sv
`timescale 1ns/1ps

module sample_capture (
    input  logic                 clk_rv,
    input  logic                 rst_rv_,
    input  logic                 sample_strobe,
    input  soc_bus_pkg::sample_t channel_a,
    input  soc_bus_pkg::sample_t channel_b,
    input  logic                 sample_clear,
    output soc_bus_pkg::stereo_t sample_pair,
    output logic                 sample_rdy,
    output logic                 sample_ovfl,
    output soc_bus_pkg::stereo_t codec_out
);
    import soc_bus_pkg::*;

    logic strobe_q;
    logic strobe_rise;

    // Doubles a sample and clamps it to the signed 16-bit range
    function automatic sample_t double_sat(input sample_t x);
        // Top two bits differ when the shift would overflow
        if (x[15] != x[14]) begin
            return x[15] ? 16'sh8000 : 16'sh7FFF;
        end
        return {x[14:0], 1'b0};
    endfunction

    assign strobe_rise = sample_strobe && !strobe_q;

    // --------------------------------------------------------------------------
    // Flags and codec output
    // --------------------------------------------------------------------------

    // A capture on the same edge as a clear takes priority
    always_ff @(posedge clk_rv) begin
        if (!rst_rv_) begin
            strobe_q    <= 1'b0;
            sample_rdy  <= 1'b0;
            sample_ovfl <= 1'b0;
            codec_out   <= '0;
        end else begin
            strobe_q <= sample_strobe;
            if (strobe_rise) begin
                sample_rdy      <= 1'b1;
                sample_ovfl     <= sample_ovfl || sample_rdy;
                codec_out.left  <= double_sat(channel_a);
                codec_out.right <= double_sat(channel_b);
            end else if (sample_clear) begin
                sample_rdy  <= 1'b0;
                sample_ovfl <= 1'b0;
            end
        end
    end

    // Captured pair for the host
    always_ff @(posedge clk_rv) begin
        if (strobe_rise) begin
            sample_pair.left  <= channel_a;
            sample_pair.right <= channel_b;
        end
    end

endmodule

// File: rtl/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                  clk_rv,
    input  logic                  sel,
    input  soc_bus_pkg::region_t  region,
    input  soc_bus_pkg::bus_req_t req,
    output logic [31:0]           rdata
);
    import soc_bus_pkg::*;

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]      mem [RAM_WORDS];
    logic [31:0]      offset;
    logic [IDX_W-1:0] idx;
    logic             acc;

    assign acc    = sel && region.ram;
    assign offset = req.addr - RAM_BASE;

    // Word index wraps at the RAM size
    assign idx = IDX_W'((offset >> 2) % RAM_WORDS);

    always_ff @(posedge clk_rv) begin
        if (acc) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
            // Old word on a write, ignored by the host
            rdata <= mem[idx];
        end
    end

endmodule

// File: rtl/soc_bus_pkg.sv
package soc_bus_pkg;

    // --------------------------------------------------------------------------
    // Address map
    // --------------------------------------------------------------------------

    localparam logic [31:0] GPIO_BASE = 32'h0300_0000;
    localparam logic [31:0] GPIO_SPAN = 32'h0000_0100;
    localparam logic [31:0] RAM_BASE  = 32'h0E00_0000;

    // GPIO register word index, taken from address bits 5:2
    localparam logic [3:0] REG_DELAY_SEL   = 4'd0;
    localparam logic [3:0] REG_LEDS        = 4'd1;
    localparam logic [3:0] REG_SAMPLE      = 4'd2;
    localparam logic [3:0] REG_SPI_CS      = 4'd3;
    localparam logic [3:0] REG_SPI_SCK     = 4'd4;
    localparam logic [3:0] REG_SPI_MOSI    = 4'd5;
    localparam logic [3:0] REG_SPI_MISO    = 4'd6;
    localparam logic [3:0] REG_USB_RST     = 4'd7;
    localparam logic [3:0] REG_CODEC_SCL   = 4'd8;
    localparam logic [3:0] REG_CODEC_SDA   = 4'd9;
    localparam logic [3:0] REG_SAMPLE_STAT = 4'd12;

    localparam int unsigned DELAY_SEL_W = 5;

    // Returned for any access outside the mapped regions
    localparam logic [31:0] BUS_ERROR_DATA = 32'hFFFF_FFFF;

    // --------------------------------------------------------------------------
    // Bus and pin types
    // --------------------------------------------------------------------------

    // Non-zero wstrb marks a write
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } bus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } bus_rsp_t;

    // One-hot
    typedef struct packed {
        logic gpio;
        logic ram;
        logic unmapped;
    } region_t;

    typedef struct packed {
        logic led_red_b;
        logic led_green_b;
        logic led_blue_b;
        logic spi_cs_b;
        logic spi_sck;
        logic spi_mosi;
        logic usb_reset_b;
        logic codec_scl_drive_low;
        logic codec_sda_drive_low;
    } gpio_pins_t;

    typedef struct packed {
        logic spi_miso;
        logic codec_scl_in;
        logic codec_sda_in;
    } pin_in_t;

    typedef logic signed [15:0] sample_t;

    // Left sits in the upper half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

endpackage

// File: tb.f
rtl/soc_bus_pkg.sv
rtl/region_decode.sv
rtl/gpio_regs.sv
rtl/sample_capture.sv
rtl/scratch_ram.sv
rtl/bus_response.sv
rtl/bus_fabric_top.sv
verification/tb_clock_gen.sv
verification/tb_bus_fabric.sv

// File: verification/tb_bus_fabric.sv
`timescale 1ns/1ps

module tb_bus_fabric;
    import soc_bus_pkg::*;

    localparam int RAM_WORDS    = 256;
    localparam int RESET_CYCLES = 16;
    localparam int READY_LIMIT  = 10;
    localparam int RAM_ROUNDS   = 8;
    localparam int SEED         = 40716;
    localparam logic [DELAY_SEL_W-1:0] DELAY_DET = 5'h13;

    typedef enum logic [2:0] {K_WRITE, K_READ, K_BAD_WRITE, K_STROBE, K_PINS, K_IRQ} kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_val;
    } entry_t;

    logic                   clk_rv;
    logic                   rst_rv_;
    bus_req_t               req;
    logic [DELAY_SEL_W-1:0] delay_sel_det;
    pin_in_t                pins_in;
    logic                   sample_strobe;
    sample_t                channel_a;
    sample_t                channel_b;
    bus_rsp_t               rsp;
    gpio_pins_t             pins_out;
    logic [DELAY_SEL_W-1:0] delay_sel;
    stereo_t                codec_out;
    logic                   bus_error;

    entry_t stim_q[$];
    bit     stim_built;
    int     checks;
    int     mismatches;
    int     other_errors;

    tb_clock_gen #(.PERIOD_NS(8)) u_clock_gen (.clk_rv(clk_rv));

    bus_fabric_top #(
        .RAM_WORDS(RAM_WORDS)
    ) uut (
        .clk_rv       (clk_rv),
        .rst_rv_      (rst_rv_),
        .req          (req),
        .delay_sel_det(delay_sel_det),
        .pins_in      (pins_in),
        .sample_strobe(sample_strobe),
        .channel_a    (channel_a),
        .channel_b    (channel_b),
        .rsp          (rsp),
        .pins_out     (pins_out),
        .delay_sel    (delay_sel),
        .codec_out    (codec_out),
        .bus_error    (bus_error)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] reg_addr(input logic [3:0] idx);
        return GPIO_BASE + {26'd0, idx, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp_val);
        checks++;
        if (got !== exp_val) begin
            mismatches++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp_val);
        end
    endtask

    task automatic add_entry(input kind_t kind, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             input logic [31:0] exp_val);
        stim_q.push_back({kind, addr, data, strb, exp_val});
    endtask

    // One single-word access that returns the read data seen with ready
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        rdata  = 'x;
        @(posedge clk_rv);
        req <= {1'b1, addr, wdata, wstrb};
        do begin
            @(negedge clk_rv);
            cycles++;
        end while (!rsp.ready && cycles < READY_LIMIT);
        if (!rsp.ready) begin
            other_errors++;
            $display("Error: no ready within %0d cycles for address %h", READY_LIMIT, addr);
        end else begin
            rdata = rsp.rdata;
            // Edge N follows the drive edge and the host samples ready at N+2
            check_value("rsp.ready latency", cycles - 1, 2);
        end
        @(posedge clk_rv);
        req.valid <= 1'b0;
        @(negedge clk_rv);
        check_value("rsp.ready", rsp.ready, 1'b0);
    endtask

    // Strobe held high over two edges with a steady pair
    task automatic pulse_strobe(input logic [31:0] pair);
        @(posedge clk_rv);
        channel_a     <= pair[31:16];
        channel_b     <= pair[15:0];
        sample_strobe <= 1'b1;
        repeat (2) @(posedge clk_rv);
        sample_strobe <= 1'b0;
        @(negedge clk_rv);
    endtask

    // Full word, then a partial overwrite, then readback against a byte merge
    task automatic ram_merge_rounds();
        logic [31:0] addr;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] merged;
        logic [31:0] rdata;
        logic [3:0]  mask;
        for (int r = 0; r < RAM_ROUNDS; r++) begin
            addr   = RAM_BASE + 4 * ($urandom % RAM_WORDS);
            first  = $urandom;
            second = $urandom;
            mask   = 4'($urandom % 14 + 1);
            for (int b = 0; b < 4; b++) begin
                merged[8*b +: 8] = mask[b] ? second[8*b +: 8] : first[8*b +: 8];
            end
            bus_access(addr, first, 4'hF, rdata);
            bus_access(addr, second, mask, rdata);
            bus_access(addr, 32'd0, 4'h0, rdata);
            check_value("rsp.rdata", rdata, merged);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    task automatic build_table();
        add_entry(K_READ, reg_addr(REG_DELAY_SEL), 0, 0, 32'(DELAY_DET));
        add_entry(K_READ, reg_addr(REG_LEDS), 0, 0, 0);
        add_entry(K_PINS, 0, 0, 0, 32'h1E0);
        // LEDs red and green on
        add_entry(K_WRITE, reg_addr(REG_LEDS), 32'h6, 4'hF, 0);
        add_entry(K_READ, reg_addr(REG_LEDS), 0, 0, 32'h6);
        add_entry(K_PINS, 0, 0, 0, 32'h060);
        add_entry(K_WRITE, reg_addr(REG_SPI_CS), 32'h0, 4'hF, 0);
        add_entry(K_WRITE, reg_addr(REG_SPI_SCK), 32'h1, 4'hF, 0);
        add_entry(K_WRITE, reg_addr(REG_SPI_MOSI), 32'h3, 4'hF, 0);
        add_entry(K_WRITE, reg_addr(REG_USB_RST), 32'h1, 4'hF, 0);
        add_entry(K_PINS, 0, 0, 0, 32'h05C);
        add_entry(K_WRITE, reg_addr(REG_SPI_SCK), 32'hFFFF_FFFE, 4'hF, 0);
        add_entry(K_WRITE, reg_addr(REG_CODEC_SCL), 32'h0, 4'hF, 0);
        add_entry(K_PINS, 0, 0, 0, 32'h04E);
        add_entry(K_WRITE, reg_addr(REG_CODEC_SDA), 32'h0, 4'hF, 0);
        add_entry(K_PINS, 0, 0, 0, 32'h04F);
        add_entry(K_WRITE, reg_addr(REG_DELAY_SEL), 32'h3A, 4'hF, 0);
        add_entry(K_READ, reg_addr(REG_DELAY_SEL), 0, 0, 32'h1A);
        // pins_in holds miso 1, scl 0, sda 1
        add_entry(K_READ, reg_addr(REG_SPI_MISO), 0, 0, 32'h1);
        add_entry(K_READ, reg_addr(REG_CODEC_SCL), 0, 0, 32'h0);
        add_entry(K_READ, reg_addr(REG_CODEC_SDA), 0, 0, 32'h1);
        add_entry(K_READ, reg_addr(REG_USB_RST), 0, 0, 32'h0);
        // Codec values are each channel doubled and clamped
        add_entry(K_READ, reg_addr(REG_SAMPLE_STAT), 0, 0, 32'h0);
        add_entry(K_STROBE, 0, 32'h1234_F000, 0, 32'h2468_E000);
        add_entry(K_READ, reg_addr(REG_SAMPLE_STAT), 0, 0, 32'h1);
        add_entry(K_STROBE, 0, 32'h4000_8001, 0, 32'h7FFF_8000);
        add_entry(K_READ, reg_addr(REG_SAMPLE_STAT), 0, 0, 32'h3);
        add_entry(K_READ, reg_addr(REG_SAMPLE), 0, 0, 32'h4000_8001);
        add_entry(K_READ, reg_addr(REG_SAMPLE_STAT), 0, 0, 32'h0);
        add_entry(K_STROBE, 0, 32'hC000_3FFF, 0, 32'h8000_7FFE);
        // First unmapped address sits one RAM size above the RAM base
        add_entry(K_IRQ, 0, 0, 0, 32'h0);
        add_entry(K_READ, RAM_BASE + 4 * RAM_WORDS, 0, 0, 32'hFFFF_FFFF);
        add_entry(K_IRQ, 0, 0, 0, 32'h1);
        add_entry(K_BAD_WRITE, GPIO_BASE + GPIO_SPAN, 32'h1, 4'hF, 32'hFFFF_FFFF);
        add_entry(K_READ, 32'h0000_1000, 0, 0, 32'hFFFF_FFFF);
        add_entry(K_READ, reg_addr(REG_LEDS), 0, 0, 32'h6);
        add_entry(K_IRQ, 0, 0, 0, 32'h1);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int unsigned seed_sink;
        logic [31:0] rdata;
        entry_t      e;
        seed_sink = $urandom(SEED);
        $timeformat(-9, 0, " ns", 0);
        rst_rv_       <= 1'b0;
        req           <= '0;
        delay_sel_det <= DELAY_DET;
        pins_in       <= 3'b101;
        sample_strobe <= 1'b0;
        channel_a     <= '0;
        channel_b     <= '0;
        build_table();
        stim_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_rv);
        rst_rv_ <= 1'b1;
        @(negedge clk_rv);
        check_value("codec_out", codec_out, 32'h0);
        check_value("bus_error", bus_error, 1'b0);
        check_value("delay_sel", delay_sel, 32'(DELAY_DET));
        foreach (stim_q[i]) begin
            e = stim_q[i];
            case (e.kind)
                K_WRITE: bus_access(e.addr, e.data, e.strb, rdata);
                K_BAD_WRITE: begin
                    bus_access(e.addr, e.data, e.strb, rdata);
                    check_value("rsp.rdata", rdata, e.exp_val);
                end
                K_READ: begin
                    bus_access(e.addr, 32'd0, 4'h0, rdata);
                    check_value("rsp.rdata", rdata, e.exp_val);
                end
                K_STROBE: begin
                    pulse_strobe(e.data);
                    check_value("codec_out", codec_out, e.exp_val);
                end
                K_PINS: check_value("pins_out", pins_out, e.exp_val);
                default: check_value("bus_error", bus_error, e.exp_val);
            endcase
        end
        // Low five bits of the last delay select write
        check_value("delay_sel", delay_sel, 32'h1A);
        ram_merge_rounds();
        // Sticky through all the legal RAM traffic
        check_value("bus_error", bus_error, 1'b1);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Twenty cycles per table entry and per RAM access, plus reset
    initial begin
        int limit;
        wait (stim_built);
        limit = RESET_CYCLES + 20 * (stim_q.size() + 3 * RAM_ROUNDS);
        repeat (limit) @(posedge clk_rv);
        $display("Error: watchdog expired after %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_rv
);

    initial begin
        clk_rv = 1'b0;
        forever #(PERIOD_NS / 2) clk_rv = ~clk_rv;
    end

endmodule
